//--- common/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Instruction type, opcode bits 7:6
	typedef enum logic [1:0] {
		OP_MOV    = 2'd0, // Bus move mid -> sid
		OP_MVI    = 2'd1, // Immediate byte after opcode -> sid
		OP_ALU    = 2'd2, // A op B -> A, flags updated
		OP_OTHERS = 2'd3  // Compare/jump and system ops
	} op_type_e;

	// Single field layout for every type
	// mid/sid meaning depends on op_type
	typedef struct packed {
		op_type_e   op_type; // 7:6
		logic [2:0] mid;     // 5:3, bit 5 is the cmp flag for OTHERS
		logic [2:0] sid;     // 2:0, alu_op, flip + flag select, or sys op
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0, // A + B, carry out
		ALU_SUB = 3'd1, // A - B, carry is borrow
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_NOT = 3'd5, // ~A
		ALU_INC = 3'd6, // A + 1, carry out
		ALU_DEC = 3'd7  // A - 1, carry is borrow
	} alu_op_e;

	// Doubles as bit index into the status register
	typedef enum logic [1:0] {
		FLAG_CARRY  = 2'd0,
		FLAG_PARITY = 2'd1, // XOR of all result bits
		FLAG_ZERO   = 2'd2,
		FLAG_SIGN   = 2'd3  // Result bit 7
	} flag_sel_e;

	typedef enum logic [2:0] {
		SYS_NOP    = 3'd0,
		SYS_HLT    = 3'd1,
		SYS_INC_AR = 3'd2
	} sys_op_e;

	// OTHERS split: compare when bit 5 set
	function automatic logic is_cmp(instr_t i);
		return i.mid[2];
	endfunction

	function automatic logic cmp_flip(instr_t i);
		return i.sid[2]; // Inverts the tested flag
	endfunction

	function automatic flag_sel_e cmp_flag(instr_t i);
		return flag_sel_e'(i.sid[1:0]);
	endfunction

	function automatic sys_op_e sys_op(instr_t i);
		return sys_op_e'(i.sid);
	endfunction

endpackage

//--- common/cpu_bus_pkg.sv
package cpu_bus_pkg;

	// RAM size range, default used by the top level
	localparam int RAM_DEPTH_DEF = 256;
	localparam int RAM_DEPTH_MIN = 64;
	localparam int RAM_DEPTH_MAX = 256;

	// Address bit 15 selects the output port over RAM
	localparam int PORT_BIT = 15;

	// Same table for bus master and bus slave
	typedef enum logic [2:0] {
		U_IR0 = 3'd0, // As master, IR0 drives the bus
		U_MEM = 3'd1,
		U_A   = 3'd2,
		U_B   = 3'd3,
		U_AR0 = 3'd4, // AR low byte
		U_AR1 = 3'd5, // AR high byte
		U_PC0 = 3'd6,
		U_PC1 = 3'd7
	} unit_id_e;

	// Address bus master
	typedef enum logic {
		ASEL_PC = 1'b0,
		ASEL_AR = 1'b1
	} addr_sel_e;

	typedef struct packed {
		unit_id_e              mid;      // Data bus master
		unit_id_e              sid;      // Data bus slave
		logic                  bus_en;   // mid/sid valid this cycle
		addr_sel_e             addr_sel;
		logic                  pc_inc;
		logic                  ar_inc;
		logic                  alu_en;   // Writes A and flags
		cpu_isa_pkg::alu_op_e  alu_op;
		logic                  halt_req; // HLT in T1
	} ctrl_word_t;

	// Program load request, held stable while ld_req is high
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
	} load_req_t;

endpackage

//--- control/control_unit.sv
module control_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    run,
	input  logic                    restart,
	input  cpu_isa_pkg::instr_t     ir,
	input  logic [3:0]              flags,
	output logic                    t1,
	output cpu_bus_pkg::ctrl_word_t ctrl
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	logic    t_state; // 0 fetch, 1 execute
	logic    op_mov;
	logic    op_mvi;
	logic    op_alu;
	logic    op_cmp;
	logic    op_sys;
	logic    cmp_pass;
	sys_op_e sop;

	// T-state timer, two states per instruction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			t_state <= 1'b0;
		end else if (restart) begin
			t_state <= 1'b0; // Next run cycle is a fetch
		end else if (run) begin
			t_state <= ~t_state;
		end
	end

	assign t1 = t_state;

	// Type decode, suppressed during fetch since IR0 still holds the old opcode
	always_comb begin
		op_mov = t1 && (ir.op_type == OP_MOV);
		op_mvi = t1 && (ir.op_type == OP_MVI);
		op_alu = t1 && (ir.op_type == OP_ALU);
		op_cmp = t1 && (ir.op_type == OP_OTHERS) && is_cmp(ir);
		op_sys = t1 && (ir.op_type == OP_OTHERS) && !is_cmp(ir);
	end

	assign sop      = sys_op(ir);
	assign cmp_pass = flags[cmp_flag(ir)] ^ cmp_flip(ir); // Flag selected, optionally inverted

	// Control word
	always_comb begin
		ctrl          = '0;
		ctrl.mid      = U_MEM;  // Fetch and immediate both read MEM
		ctrl.sid      = U_IR0;
		ctrl.addr_sel = ASEL_PC;
		ctrl.alu_op   = alu_op_e'(ir.sid);

		if (!t1) begin
			// T0 fetch, MEM[PC] -> IR0 and step PC
			ctrl.bus_en = run;
			ctrl.pc_inc = 1'b1;
		end

		if (op_mov) begin
			ctrl.mid    = unit_id_e'(ir.mid);
			ctrl.sid    = unit_id_e'(ir.sid);
			ctrl.bus_en = run;
			// Memory operand always addressed through AR
			if (ir.mid == U_MEM || ir.sid == U_MEM) begin
				ctrl.addr_sel = ASEL_AR;
			end
		end

		if (op_mvi) begin
			ctrl.sid    = unit_id_e'(ir.sid); // Byte at PC -> sid
			ctrl.bus_en = run;
			ctrl.pc_inc = 1'b1;               // Step past the immediate
		end

		if (op_alu) begin
			ctrl.alu_en = 1'b1;
		end

		if (op_cmp) begin
			if (cmp_pass) begin
				ctrl.sid    = U_PC0; // Jump within page, PC1 kept
				ctrl.bus_en = run;
			end else begin
				ctrl.pc_inc = 1'b1;  // Skip target byte
			end
		end

		if (op_sys) begin
			ctrl.halt_req = (sop == SYS_HLT);
			ctrl.ar_inc   = (sop == SYS_INC_AR);
		end
	end

endmodule

//--- datapath/cpu_datapath.sv
module cpu_datapath (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    run,
	input  logic                    restart,
	input  cpu_bus_pkg::ctrl_word_t ctrl,
	input  logic [7:0]              mem_rdata,
	output logic [15:0]             addr,
	output logic [7:0]              mem_wdata,
	output logic                    mem_rd,
	output logic                    mem_wr,
	output cpu_isa_pkg::instr_t     ir,
	output logic [3:0]              flags
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	logic [7:0]  oe;         // One-hot bus master
	logic [7:0]  we;         // One-hot bus slave
	logic [7:0]  src [8];    // Master candidates by unit id
	logic [7:0]  bus;
	logic [7:0]  a_q;
	logic [7:0]  b_q;
	logic [15:0] ar_q;
	logic [15:0] pc_q;
	logic [7:0]  alu_y;
	logic        alu_c;
	logic [3:0]  flags_next;
	logic        alu_wr;

	// Next value of a 16-bit pointer with byte writes
	// Increment first, a bus write then replaces its byte
	function automatic logic [15:0] ptr_next(
		input logic [15:0] cur,
		input logic        inc,
		input logic        we_lo,
		input logic        we_hi,
		input logic [7:0]  d
	);
		logic [15:0] nxt;
		nxt = inc ? cur + 16'd1 : cur;
		if (we_lo) begin
			nxt[7:0] = d;
		end
		if (we_hi) begin
			nxt[15:8] = d;
		end
		return nxt;
	endfunction

	// mid/sid decode
	always_comb begin
		oe = '0;
		we = '0;
		if (ctrl.bus_en) begin
			oe[ctrl.mid] = 1'b1;
			we[ctrl.sid] = run; // No writes while halted
		end
	end

	assign src[U_IR0] = ir;
	assign src[U_MEM] = mem_rdata;
	assign src[U_A]   = a_q;
	assign src[U_B]   = b_q;
	assign src[U_AR0] = ar_q[7:0];
	assign src[U_AR1] = ar_q[15:8];
	assign src[U_PC0] = pc_q[7:0];
	assign src[U_PC1] = pc_q[15:8];

	// AND-OR bus mux
	always_comb begin
		bus = '0;
		for (int i = 0; i < 8; i++) begin
			bus |= oe[i] ? src[i] : 8'h00;
		end
	end

	assign mem_rd    = oe[U_MEM];
	assign mem_wr    = we[U_MEM];
	assign mem_wdata = bus;
	assign addr      = (ctrl.addr_sel == ASEL_AR) ? ar_q : pc_q; // Address master

	// ALU on A and B
	always_comb begin
		alu_y = a_q;
		alu_c = 1'b0;
		case (ctrl.alu_op)
			ALU_ADD: {alu_c, alu_y} = {1'b0, a_q} + {1'b0, b_q};
			ALU_SUB: {alu_c, alu_y} = {1'b0, a_q} - {1'b0, b_q}; // Bit 8 set on borrow
			ALU_AND: alu_y = a_q & b_q;
			ALU_OR:  alu_y = a_q | b_q;
			ALU_XOR: alu_y = a_q ^ b_q;
			ALU_NOT: alu_y = ~a_q;
			ALU_INC: {alu_c, alu_y} = {1'b0, a_q} + 9'd1;
			ALU_DEC: {alu_c, alu_y} = {1'b0, a_q} - 9'd1; // Borrow only from 0x00
			default: alu_y = a_q;
		endcase
		flags_next[FLAG_CARRY]  = alu_c;
		flags_next[FLAG_PARITY] = ^alu_y;
		flags_next[FLAG_ZERO]   = (alu_y == 8'h00);
		flags_next[FLAG_SIGN]   = alu_y[7];
	end

	assign alu_wr = run && ctrl.alu_en;

	// Data registers
	always_ff @(posedge clk) begin
		if (alu_wr) begin
			a_q <= alu_y;
		end else if (we[U_A]) begin
			a_q <= bus;
		end
		if (we[U_B]) begin
			b_q <= bus;
		end
		ar_q <= ptr_next(ar_q, run && ctrl.ar_inc, we[U_AR0], we[U_AR1], bus);
	end

	// PC, IR0 and status
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q  <= '0;
			ir    <= '0;
			flags <= '0;
		end else begin
			if (restart) begin
				pc_q <= '0; // Program always starts at 0x0000
			end else begin
				pc_q <= ptr_next(pc_q, run && ctrl.pc_inc, we[U_PC0], we[U_PC1], bus);
			end
			if (we[U_IR0]) begin
				ir <= instr_t'(bus);
			end
			if (alu_wr) begin
				flags <= flags_next;
			end
		end
	end

endmodule

//--- logic/program_ram.sv
module program_ram #(
	parameter int RAM_DEPTH = cpu_bus_pkg::RAM_DEPTH_DEF
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   halted,
	input  logic [15:0]            addr,
	input  logic [7:0]             wdata,
	input  logic                   rd,
	input  logic                   wr,
	output logic [7:0]             rdata,
	input  logic                   ld_req,
	input  cpu_bus_pkg::load_req_t ld,
	output logic                   ld_ack,
	output logic [7:0]             port_data,
	output logic                   port_valid
);
	import cpu_bus_pkg::*;

	localparam int AW = $clog2(RAM_DEPTH); // At most the low 8 address bits

	logic [7:0] mem [RAM_DEPTH];
	logic       ram_sel;
	logic       ram_wr;
	logic       port_wr;
	logic       ld_wr;

	if (RAM_DEPTH < RAM_DEPTH_MIN || RAM_DEPTH > RAM_DEPTH_MAX) begin : g_depth_check
		$error("program_ram: RAM_DEPTH %0d outside 64..256", RAM_DEPTH);
	end

	assign ram_sel = !addr[PORT_BIT];
	assign ram_wr  = wr && ram_sel;
	assign port_wr = wr && addr[PORT_BIT]; // Memory mapped output port
	assign ld_wr   = halted && ld_req && !ld_ack; // First cycle of a request only

	// Combinational read, same cycle as the address
	assign rdata = (rd && ram_sel) ? mem[addr[AW-1:0]] : 8'h00;

	// Loader and CPU never write together, CPU is halted during loads
	always_ff @(posedge clk) begin
		if (ld_wr) begin
			mem[ld.addr[AW-1:0]] <= ld.data;
		end else if (ram_wr) begin
			mem[addr[AW-1:0]] <= wdata;
		end
		if (port_wr) begin
			port_data <= wdata;
		end
	end

	// Four-phase ack, falls once req is seen low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_ack     <= 1'b0;
			port_valid <= 1'b0;
		end else begin
			port_valid <= port_wr; // Same edge as port_data
			if (ld_wr) begin
				ld_ack <= 1'b1;
			end else if (!ld_req) begin
				ld_ack <= 1'b0;
			end
		end
	end

endmodule

//--- logic/cpu_top.sv
module cpu_top #(
	parameter int RAM_DEPTH = cpu_bus_pkg::RAM_DEPTH_DEF
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic                   ld_req,
	input  cpu_bus_pkg::load_req_t ld,
	output logic                   ld_ack,
	output logic [7:0]             port_data,
	output logic                   port_valid,
	output logic                   halted
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	ctrl_word_t  ctrl;
	instr_t      ir;
	logic [3:0]  flags;
	logic        t1;
	logic        run;
	logic        restart;
	logic [15:0] addr;
	logic [7:0]  mem_wdata;
	logic [7:0]  mem_rdata;
	logic        mem_rd;
	logic        mem_wr;

	assign restart = start && halted; // Start ignored while running
	assign run     = !halted;

	// Run/halt, halted out of reset until start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halted <= 1'b1;
		end else if (restart) begin
			halted <= 1'b0;
		end else if (run && t1 && ctrl.halt_req) begin
			halted <= 1'b1; // End of HLT execute cycle
		end
	end

	control_unit u_control_unit (
		.clk     (clk),
		.rst_n   (rst_n),
		.run     (run),
		.restart (restart),
		.ir      (ir),
		.flags   (flags),
		.t1      (t1),
		.ctrl    (ctrl)
	);

	cpu_datapath u_cpu_datapath (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.restart   (restart),
		.ctrl      (ctrl),
		.mem_rdata (mem_rdata),
		.addr      (addr),
		.mem_wdata (mem_wdata),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.ir        (ir),
		.flags     (flags)
	);

	program_ram #(
		.RAM_DEPTH (RAM_DEPTH)
	) u_program_ram (
		.clk        (clk),
		.rst_n      (rst_n),
		.halted     (halted),
		.addr       (addr),
		.wdata      (mem_wdata),
		.rd         (mem_rd),
		.wr         (mem_wr),
		.rdata      (mem_rdata),
		.ld_req     (ld_req),
		.ld         (ld),
		.ld_ack     (ld_ack),
		.port_data  (port_data),
		.port_valid (port_valid)
	);

endmodule

//--- testbench/cpu_chk.sv
module cpu_chk (
	input logic clk,
	input logic rst_n,
	input logic ld_req,
	input logic ld_ack,
	input logic halted,
	input logic port_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// Ack only rises on a pending request
	ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ld_ack) |-> $past(ld_req))
		else $error("ld_ack rose without ld_req");

	// RAM accepts no load while the CPU runs
	no_load_running: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ld_ack) |-> $past(halted))
		else $error("load accepted while CPU running");

	port_pulse_one: assert property (@(posedge clk) disable iff (!rst_n)
		port_valid |=> !port_valid)
		else $error("port_valid held longer than one cycle");

endmodule

bind cpu_top cpu_chk u_cpu_chk (.*);

//--- testbench/cpu_monitor.sv
module cpu_monitor (
	input logic       clk,
	input logic       port_valid,
	input logic [7:0] port_data,
	input logic       halted
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] exp_q [$]; // Port bytes still due
	int         checks;
	int         errors;

	initial begin
		checks = 0;
		errors = 0;
	end

	task expect_byte(input logic [7:0] b);
		exp_q.push_back(b);
	endtask

	// Port sampled mid-cycle, registered outputs stable there
	always @(negedge clk) begin
		if (port_valid) begin
			checks++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("Extra port write of %h after the expected sequence", port_data);
			end else begin
				if (port_data !== exp_q[0]) begin
					errors++;
					$display("ERR port_data expected %h got %h", exp_q[0], port_data);
				end
				void'(exp_q.pop_front());
			end
		end
	end

	// Called once a program has had time to finish
	task end_check(input logic exp_halt);
		checks++;
		if (halted !== exp_halt) begin
			errors++;
			$display("ERR halted expected %h got %h", exp_halt, halted);
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("Missing %0d port writes, next expected %h", exp_q.size(), exp_q[0]);
			exp_q.delete();
		end
	endtask

endmodule

//--- testbench/tb_cpu.sv
module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_bus_pkg::*;

	localparam int N_PROG    = 2;
	localparam int MAX_INSTR = 256; // Forward jumps only so at most one instruction per byte
	localparam int WD_CYCLES = 16 + N_PROG * (2 * MAX_INSTR + 256 * 8) + 2000;

	logic       clk;
	logic       rst_n;
	logic       start;
	logic       ld_req;
	load_req_t  ld;
	logic       ld_ack;
	logic [7:0] port_data;
	logic       port_valid;
	logic       halted;

	logic [31:0] lcg_state;
	logic [7:0]  prog [256];
	int          prog_len;
	logic [7:0]  exp_q [$];
	logic        exp_halt;

	// Model state
	logic [7:0]  m_mem [256];
	logic [15:0] m_pc;
	logic [15:0] m_ar;
	logic [7:0]  m_a;
	logic [7:0]  m_b;
	logic [7:0]  m_ir;
	logic [3:0]  m_fl; // sign, zero, parity, carry

	cpu_top u_cpu_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.ld_req     (ld_req),
		.ld         (ld),
		.ld_ack     (ld_ack),
		.port_data  (port_data),
		.port_valid (port_valid),
		.halted     (halted)
	);

	cpu_monitor u_cpu_monitor (
		.clk        (clk),
		.port_valid (port_valid),
		.port_data  (port_data),
		.halted     (halted)
	);

	always #20 clk = ~clk;

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16]; // Upper bits spread better
	endfunction

	task put(input logic [7:0] b);
		prog[prog_len] = b;
		prog_len++;
	endtask

	task put_mvi(input logic [2:0] sid, input logic [7:0] v);
		put({5'b01000, sid});
		put(v);
	endtask

	task put_mov(input logic [2:0] mid, input logic [2:0] sid);
		put({2'b00, mid, sid});
	endtask

	// Unit ids are IR0 0, MEM 1, A 2, B 3, AR0 4, AR1 5, PC0 6, PC1 7
	task build_program();
		logic [7:0] cmp;
		int         tx;
		int         te;
		prog_len = 0;
		for (int i = 0; i < 256; i++) begin
			prog[i] = 8'hc0; // NOP fill
		end
		put_mvi(3'd5, 8'h80); // AR at the output port
		put_mvi(3'd4, 8'h00);
		// Register moves to the port
		put_mvi(3'd2, lcg_byte());
		put_mov(3'd2, 3'd1);
		put_mvi(3'd3, lcg_byte());
		put_mov(3'd3, 3'd1);
		put_mov(3'd3, 3'd2);
		put_mov(3'd2, 3'd1);
		// Each ALU op followed by a branch on flag i%4 with flip i/4
		for (int i = 0; i < 8; i++) begin
			put_mvi(3'd2, (i == 2) ? (lcg_byte() & 8'h0f) : lcg_byte());
			put_mvi(3'd3, (i == 2) ? (lcg_byte() & 8'hf0) : lcg_byte());
			put(8'h80 | 8'(i));
			put_mov(3'd2, 3'd1);
			cmp = 8'he0 | 8'(i);
			put(cmp);
			tx = prog_len;
			put(8'h00);
			put_mvi(3'd2, 8'h59); // Skipped marker
			put_mov(3'd2, 3'd1);
			put(cmp ^ 8'h04); // Opposite condition is always taken here
			te = prog_len;
			put(8'h00);
			prog[tx] = 8'(prog_len);
			put_mvi(3'd2, 8'h58); // Taken marker
			put_mov(3'd2, 3'd1);
			prog[te] = 8'(prog_len);
		end
		// Store four bytes at 0xf0 upward
		put_mvi(3'd5, 8'h00);
		put_mvi(3'd4, 8'hf0);
		for (int k = 0; k < 4; k++) begin
			put_mvi(3'd2, lcg_byte());
			put_mov(3'd2, 3'd1);
			put(8'hc2); // INC_AR
		end
		put_mvi(3'd4, 8'hf0);
		for (int k = 0; k < 4; k++) begin
			put_mov(3'd1, 3'd3);
			put_mvi(3'd5, 8'h80);
			put_mov(3'd3, 3'd1);
			put_mvi(3'd5, 8'h00);
			put(8'hc2);
		end
		put(8'hc1); // HLT
		put_mov(3'd3, 3'd1); // Must never run
	endtask

	function automatic logic [7:0] mem_read(input logic [15:0] a);
		return a[15] ? 8'h00 : m_mem[a[7:0]];
	endfunction

	function automatic void mem_write(input logic [15:0] a, input logic [7:0] v);
		if (a[15]) begin
			exp_q.push_back(v);
		end else begin
			m_mem[a[7:0]] = v;
		end
	endfunction

	function automatic logic [7:0] unit_value(input logic [2:0] id);
		case (id)
			3'd0: return m_ir;
			3'd1: return mem_read(m_ar);
			3'd2: return m_a;
			3'd3: return m_b;
			3'd4: return m_ar[7:0];
			3'd5: return m_ar[15:8];
			3'd6: return m_pc[7:0];
			default: return m_pc[15:8];
		endcase
	endfunction

	function automatic void unit_write(input logic [2:0] id, input logic [7:0] v);
		case (id)
			3'd0: m_ir = v;
			3'd1: mem_write(m_ar, v);
			3'd2: m_a = v;
			3'd3: m_b = v;
			3'd4: m_ar[7:0] = v;
			3'd5: m_ar[15:8] = v;
			3'd6: m_pc[7:0] = v;
			default: m_pc[15:8] = v;
		endcase
	endfunction

	// ISA model filling exp_q and returning the expected halt state
	function automatic logic expected_ports();
		logic [8:0] r;
		logic [7:0] v;
		exp_q.delete();
		for (int i = 0; i < 256; i++) begin
			m_mem[i] = prog[i];
		end
		m_pc = 16'h0000;
		m_fl = 4'h0;
		for (int steps = 0; steps < MAX_INSTR; steps++) begin
			m_ir = mem_read(m_pc);
			m_pc++;
			case (m_ir[7:6])
				2'd0: unit_write(m_ir[2:0], unit_value(m_ir[5:3]));
				2'd1: begin
					v = mem_read(m_pc);
					m_pc++;
					unit_write(m_ir[2:0], v);
				end
				2'd2: begin
					case (m_ir[2:0])
						3'd0: r = {1'b0, m_a} + {1'b0, m_b};
						3'd1: r = {(m_a < m_b), m_a - m_b};
						3'd2: r = {1'b0, m_a & m_b};
						3'd3: r = {1'b0, m_a | m_b};
						3'd4: r = {1'b0, m_a ^ m_b};
						3'd5: r = {1'b0, ~m_a};
						3'd6: r = {(m_a == 8'hff), m_a + 8'd1};
						default: r = {(m_a == 8'h00), m_a - 8'd1};
					endcase
					m_a = r[7:0];
					m_fl = {r[7], (r[7:0] == 8'h00), ^r[7:0], r[8]};
				end
				default: begin
					if (m_ir[5]) begin
						if (m_fl[m_ir[1:0]] ^ m_ir[2]) begin
							m_pc[7:0] = mem_read(m_pc); // Same page
						end else begin
							m_pc++;
						end
					end else if (m_ir[2:0] == 3'd1) begin
						return 1'b1;
					end else if (m_ir[2:0] == 3'd2) begin
						m_ar++;
					end
				end
			endcase
		end
		return 1'b0;
	endfunction

	// Four-phase write of one byte
	task load_byte(input logic [7:0] a, input logic [7:0] d);
		ld.addr = a;
		ld.data = d;
		ld_req = 1'b1;
		do @(negedge clk); while (!ld_ack);
		ld_req = 1'b0;
		do @(negedge clk); while (ld_ack);
	endtask

	// Request over the HLT byte held a few cycles mid-run and ignored by the RAM
	task load_while_running();
		ld.addr = 8'(prog_len - 2);
		ld.data = 8'h00;
		ld_req = 1'b1;
		repeat (4) @(negedge clk);
		ld_req = 1'b0;
		@(negedge clk);
	endtask

	task run_program();
		build_program();
		exp_halt = expected_ports();
		for (int i = 0; i < exp_q.size(); i++) begin
			u_cpu_monitor.expect_byte(exp_q[i]);
		end
		for (int i = 0; i < prog_len; i++) begin
			load_byte(8'(i), prog[i]);
		end
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		load_while_running();
		while (!halted) @(negedge clk);
		repeat (8) @(negedge clk); // Catch writes after HLT
		u_cpu_monitor.end_check(exp_halt);
	endtask

	// Watchdog
	initial begin
		#(WD_CYCLES * 40);
		$display("Timeout: CPU did not halt within %0d cycles", WD_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		ld_req = 1'b0;
		ld = '0;
		lcg_state = 32'h399c;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int p = 0; p < N_PROG; p++) begin
			run_program(); // Second pass reloads and restarts from PC 0
		end
		$display("checks %0d errors %0d", u_cpu_monitor.checks, u_cpu_monitor.errors);
		if (u_cpu_monitor.errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- sources.f
common/cpu_isa_pkg.sv
common/cpu_bus_pkg.sv
control/control_unit.sv
datapath/cpu_datapath.sv
logic/program_ram.sv
logic/cpu_top.sv
testbench/cpu_chk.sv
testbench/cpu_monitor.sv
testbench/tb_cpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f sources.f -o Vtb_cpu

./obj_dir/Vtb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -qF '** FAIL **' sim.log || ! grep -qF '** PASS **' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
